// File: hw/pBusPkg.sv
`default_nettype none

package pBusPkg;

	// Slot index of the 16-slot P-bus cycle
	typedef logic [3:0] slotNum_t;

	// Slot map, one word per slot range
	localparam slotNum_t slotSt = 4'd0;	// Sprite ROM address
	localparam slotNum_t slotLoFirst = 4'd1;	// L0 ROM address start
	localparam slotNum_t slotLoLast = 4'd5;	// L0 ROM address end
	localparam slotNum_t slotSp = 4'd6;	// Sprite palette
	localparam slotNum_t slotFtFirst = 4'd7;	// Fix ROM address start
	localparam slotNum_t slotFtLast = 4'd8;	// Fix ROM address end
	localparam slotNum_t slotXFirst = 4'd9;	// Sprite X start
	localparam slotNum_t slotXLast = 4'd13;	// Sprite X end
	localparam slotNum_t slotFpFirst = 4'd14;	// Fix palette start
	localparam slotNum_t slotFpLast = 4'd15;	// Fix palette end

	// Field widths
	localparam int fixAddrW = 16;	// Fix ROM address
	localparam int l0AddrW = 16;	// L0 ROM address
	localparam int sprAddrW = 24;	// Sprite ROM address, full bus width
	localparam int palW = 8;	// Sprite palette, also X position
	localparam int fixPalW = 4;	// Fix palette

	// Field view of the bus word
	// Fix palette rides in the low nibble of the sprPal byte, bits 19 to 16
	typedef struct packed {
		logic [palW-1:0] sprPal;	// Bits 23 to 16
		logic [palW-1:0] xPos;	// Bits 15 to 8
		logic [7:0] pad;	// Always zero
	} pBusField_t;

	// One P-bus word, read as address or as fields
	typedef union packed {
		logic [sprAddrW-1:0] addr;	// Sprite, fix and L0 addresses
		pBusField_t field;	// Palette and X slots
	} pBusWord_u;

endpackage

`default_nettype wire

// File: hw/pBusIf.sv
`timescale 1ns/100ps
`default_nettype none

interface pBusIf
	import pBusPkg::*;
();

	slotNum_t slot;	// Current slot
	pBusWord_u word;	// Word on the P bus this slot

	// Fields held by the latch stage
	logic [fixAddrW-1:0] fixRomAddr;	// Held fix ROM address
	logic [sprAddrW-1:0] sprRomAddr;	// Held sprite ROM address
	logic [palW-1:0] sprPal;	// Held sprite palette
	logic [palW-1:0] sprXpos;	// Held sprite X
	logic [fixPalW-1:0] fixPal;	// Held fix palette

	// Slot counter and bus mux
	modport seq (
		output slot,
		output word
	);

	// External address latch model
	modport latch (
		input slot,
		input word,
		output fixRomAddr,
		output sprRomAddr,
		output sprPal,
		output sprXpos,
		output fixPal
	);

	// Fix pixel stage
	modport pix (
		input slot,
		input fixPal
	);

endinterface

`default_nettype wire

// File: hw/pCycleSeq.sv
`timescale 1ns/100ps
`default_nettype none

module pCycleSeq
	import pBusPkg::*;
(
	input logic CLK_24M,
	input logic nRESET,
	input logic [fixAddrW-1:0] sRomAddr,	// Fix ROM address from fix map
	input logic [l0AddrW-1:0] l0RomAddr,	// L0 ROM address
	input logic [sprAddrW-1:0] cRomAddr,	// Sprite ROM address
	input logic [palW-1:0] sprPal,	// Sprite palette
	input logic [palW-1:0] sprXpos,	// Sprite X position
	input logic [fixPalW-1:0] fixPal,	// Fix palette
	pBusIf.seq bus,	// Slot and word out
	output logic s1h1,	// Half-cycle strobe
	output logic nVcs	// Sprite X window, active low
);

	slotNum_t slotCnt;	// Current slot
	slotNum_t slotNext;	// Slot of the coming cycle
	pBusWord_u word;	// Word for this slot
	logic xNext;	// Coming slot is an X slot

	assign slotNext = slotCnt + 1'b1;	// Wraps at 16

	// Free-running slot counter, no stall
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			slotCnt <= '0;
		else
			slotCnt <= slotNext;
	end

	assign bus.slot = slotCnt;
	assign s1h1 = slotCnt[3];	// High in slots 8 to 15

	// Bus word per slot
	// Unused bytes read zero, no tristate here
	always_comb
	begin
		word = '0;
		case (slotCnt) inside
			slotSt:
				word.addr = cRomAddr;	// Full 24-bit sprite address
			[slotLoFirst:slotLoLast]:
				word.addr[l0AddrW-1:0] = l0RomAddr;	// Upper byte zero
			slotSp:
				word.field.sprPal = sprPal;	// Upper byte
			[slotFtFirst:slotFtLast]:
				word.addr[fixAddrW-1:0] = sRomAddr;	// Low 16 bits
			[slotXFirst:slotXLast]:
				word.field.xPos = sprXpos;	// Middle byte
			[slotFpFirst:slotFpLast]:
				word.field.sprPal[fixPalW-1:0] = fixPal;	// Bits 19 to 16
			default:
				word = '0;
		endcase
	end

	assign bus.word = word;

	// nVcs follows the X slots, one register stage
	// Decided from the next slot so the low level lines up with slot 9
	assign xNext = (slotNext >= slotXFirst) && (slotNext <= slotXLast);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			nVcs <= 1'b1;	// Inactive
		else
			nVcs <= !xNext;
	end

	// Registered strobe must sit inside the X window
	nVcsInX: assert property (
		@(posedge CLK_24M) disable iff (!nRESET)
		!nVcs |-> (slotCnt >= slotXFirst) && (slotCnt <= slotXLast)
	) else $error("nVcs low outside X slots, slot %0d", slotCnt);

endmodule

`default_nettype wire

// File: hw/pBusLatch.sv
`timescale 1ns/100ps
`default_nettype none

module pBusLatch
	import pBusPkg::*;
(
	input logic CLK_24M,
	input logic nRESET,
	pBusIf.latch bus	// Slot and word in, held fields out
);

	logic capSt;	// Last sprite address slot
	logic capSp;	// Sprite palette slot
	logic capFt;	// Last fix address slot
	logic capX;	// Last X slot
	logic capFp;	// Last fix palette slot
	logic inFp;	// Any fix palette slot

	// Capture strobes, last cycle of each range
	assign capSt = (bus.slot == slotSt);
	assign capSp = (bus.slot == slotSp);
	assign capFt = (bus.slot == slotFtLast);
	assign capX = (bus.slot == slotXLast);
	assign capFp = (bus.slot == slotFpLast);

	assign inFp = (bus.slot >= slotFpFirst) && (bus.slot <= slotFpLast);

	// Sprite ROM address, whole word
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			bus.sprRomAddr <= '0;
		else if (capSt)
			bus.sprRomAddr <= bus.word.addr;
	end

	// Sprite palette from the upper byte
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			bus.sprPal <= '0;
		else if (capSp)
			bus.sprPal <= bus.word.field.sprPal;
	end

	// Fix ROM address, low half of the word
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			bus.fixRomAddr <= '0;
		else if (capFt)
			bus.fixRomAddr <= bus.word.addr[fixAddrW-1:0];
	end

	// Sprite X from the middle byte
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			bus.sprXpos <= '0;
		else if (capX)
			bus.sprXpos <= bus.word.field.xPos;
	end

	// Fix palette, low nibble of the upper byte
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			bus.fixPal <= '0;
		else if (capFp)
			bus.fixPal <= bus.word.field.sprPal[fixPalW-1:0];
	end

	// The sequencer must leave bits 23 to 20 clear while the fix palette is out
	fpUpperZero: assert property (
		@(posedge CLK_24M) disable iff (!nRESET)
		inFp |-> (bus.word.field.sprPal[palW-1:fixPalW] == '0)
	) else $error("P bus upper nibble set in fix palette slot %0d", bus.slot);

endmodule

`default_nettype wire

// File: hw/fixPixelOut.sv
`timescale 1ns/100ps
`default_nettype none

module fixPixelOut
	import pBusPkg::*;
(
	input logic CLK_24M,
	input logic nRESET,
	pBusIf.pix bus,	// Slot and held fix palette
	input logic [7:0] fixRomData,	// Fix ROM byte, two pixels
	input logic [7:0] l0RomData,	// L0 ROM byte
	output logic [3:0] fixPixel,	// Current fix pixel
	output logic [fixPalW-1:0] fixPixelPal,	// Palette for fixPixel
	output logic [7:0] l0Data	// Held L0 byte
);

	logic [7:0] fixByte;	// Captured pixel pair
	logic capFix;	// End of fix palette slot
	logic capL0;	// End of L0 address slots
	logic secondHalf;	// Slots 8 to 15

	assign capFix = (bus.slot == slotFpLast);
	assign capL0 = (bus.slot == slotLoLast);
	assign secondHalf = bus.slot[3];	// Same as s1h1

	// Pixel pair and its palette land together
	// Palette here is the one held since the previous slot-15 edge
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			fixByte <= '0;
			fixPixelPal <= '0;
		end
		else if (capFix)
		begin
			fixByte <= fixRomData;
			fixPixelPal <= bus.fixPal;
		end
	end

	// Low nibble first, then high nibble
	assign fixPixel = secondHalf ? fixByte[7:4] : fixByte[3:0];

	// L0 byte at the end of the address window
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			l0Data <= '0;
		else if (capL0)
			l0Data <= l0RomData;
	end

	// Palette only moves right after the slot-15 edge
	fixPalOnEdge: assert property (
		@(posedge CLK_24M) disable iff (!nRESET)
		$changed(fixPixelPal) |-> ($past(bus.slot) == slotFpLast)
	) else $error("fixPixelPal changed outside slot-15 edge");

endmodule

`default_nettype wire

// File: hw/pBusTop.sv
`timescale 1ns/100ps
`default_nettype none

module pBusTop
	import pBusPkg::*;
(
	input logic CLK_24M,
	input logic nRESET,
	input logic [fixAddrW-1:0] sRomAddr,	// Fix ROM address in
	input logic [l0AddrW-1:0] l0RomAddr,	// L0 ROM address in
	input logic [sprAddrW-1:0] cRomAddr,	// Sprite ROM address in
	input logic [palW-1:0] sprPal,	// Sprite palette in
	input logic [palW-1:0] sprXpos,	// Sprite X in
	input logic [fixPalW-1:0] fixPal,	// Fix palette in
	input logic [7:0] fixRomData,	// Fix ROM byte
	input logic [7:0] l0RomData,	// L0 ROM byte
	output logic [sprAddrW-1:0] pBus,	// P bus word
	output logic s1h1,	// Slot bit 3
	output logic nVcs,	// X window, active low
	output logic [fixAddrW-1:0] fixRomAddr,	// Latched fix address
	output logic [sprAddrW-1:0] sprRomAddr,	// Latched sprite address
	output logic [palW-1:0] sprPalOut,	// Latched sprite palette
	output logic [palW-1:0] sprXposOut,	// Latched sprite X
	output logic [fixPalW-1:0] fixPalOut,	// Latched fix palette
	output logic [3:0] fixPixel,	// Fix pixel
	output logic [fixPalW-1:0] fixPixelPal,	// Fix pixel palette
	output logic [7:0] l0Data	// Latched L0 byte
);

	pBusIf bus ();	// Internal P bus

	pCycleSeq i_seq (
		.CLK_24M (CLK_24M),
		.nRESET (nRESET),
		.sRomAddr (sRomAddr),
		.l0RomAddr (l0RomAddr),
		.cRomAddr (cRomAddr),
		.sprPal (sprPal),
		.sprXpos (sprXpos),
		.fixPal (fixPal),
		.bus (bus.seq),
		.s1h1 (s1h1),
		.nVcs (nVcs)
	);

	pBusLatch i_latch (
		.CLK_24M (CLK_24M),
		.nRESET (nRESET),
		.bus (bus.latch)
	);

	fixPixelOut i_pix (
		.CLK_24M (CLK_24M),
		.nRESET (nRESET),
		.bus (bus.pix),
		.fixRomData (fixRomData),
		.l0RomData (l0RomData),
		.fixPixel (fixPixel),
		.fixPixelPal (fixPixelPal),
		.l0Data (l0Data)
	);

	// Bus and held fields out to pins
	assign pBus = bus.word.addr;
	assign fixRomAddr = bus.fixRomAddr;
	assign sprRomAddr = bus.sprRomAddr;
	assign sprPalOut = bus.sprPal;
	assign sprXposOut = bus.sprXpos;
	assign fixPalOut = bus.fixPal;

endmodule

`default_nettype wire

// File: sim/pBusTb.sv
`timescale 1ns/100ps
`default_nettype none

module pBusTb
	import pBusPkg::*;
();

	logic CLK_24M;
	logic nRESET;
	logic [15:0] sRomAddr;	// DUT inputs
	logic [15:0] l0RomAddr;
	logic [23:0] cRomAddr;
	logic [7:0] sprPal;
	logic [7:0] sprXpos;
	logic [3:0] fixPal;
	logic [7:0] fixRomData;
	logic [7:0] l0RomData;
	logic [23:0] pBus;	// DUT outputs
	logic s1h1;
	logic nVcs;
	logic [15:0] fixRomAddr;
	logic [23:0] sprRomAddr;
	logic [7:0] sprPalOut;
	logic [7:0] sprXposOut;
	logic [3:0] fixPalOut;
	logic [3:0] fixPixel;
	logic [3:0] fixPixelPal;
	logic [7:0] l0Data;

	int cycleCnt = 0;	// Cycles since reset release
	int rstEdges = 0;	// Clock edges seen in reset
	int errorCount = 0;
	int slotCycles = 0;	// Full 16-slot cycles run
	logic checkOn;	// Outputs defined from here on
	logic inReset;
	logic firstCycle;	// Slot 0 right after release
	slotNum_t expSlot;	// Slot model
	logic [23:0] expWord;	// Expected P bus word
	logic expS1h1;
	logic expNVcs;
	logic [23:0] expSprRomAddr;	// Reference latch model
	logic [7:0] expSprPal;
	logic [15:0] expFixRomAddr;
	logic [7:0] expSprXpos;
	logic [3:0] expFixPal;
	logic [7:0] expFixByte;	// Reference pixel stage
	logic [3:0] expFixPixelPal;
	logic [3:0] expFixPixel;
	logic [7:0] expL0Data;
	logic [79:0] resetView;	// All held outputs in one word
	logic [79:0] resetExp;

	pBusTop i_dut (
		.CLK_24M (CLK_24M),
		.nRESET (nRESET),
		.sRomAddr (sRomAddr),
		.l0RomAddr (l0RomAddr),
		.cRomAddr (cRomAddr),
		.sprPal (sprPal),
		.sprXpos (sprXpos),
		.fixPal (fixPal),
		.fixRomData (fixRomData),
		.l0RomData (l0RomData),
		.pBus (pBus),
		.s1h1 (s1h1),
		.nVcs (nVcs),
		.fixRomAddr (fixRomAddr),
		.sprRomAddr (sprRomAddr),
		.sprPalOut (sprPalOut),
		.sprXposOut (sprXposOut),
		.fixPalOut (fixPalOut),
		.fixPixel (fixPixel),
		.fixPixelPal (fixPixelPal),
		.l0Data (l0Data)
	);

	always #5 CLK_24M = ~CLK_24M;	// 10 ns period

	always @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			cycleCnt <= 0;
			rstEdges <= rstEdges + 1;
		end
		else
			cycleCnt <= cycleCnt + 1;
	end

	assign expSlot = cycleCnt[3:0];	// Modulo 16
	assign checkOn = (rstEdges >= 1);
	assign inReset = !nRESET && (rstEdges >= 1);
	assign firstCycle = nRESET && (cycleCnt == 0);

	// Slot map of the P bus, unused bytes zero
	always_comb
	begin
		expWord = 24'h0;
		if (expSlot == slotSt)
			expWord = cRomAddr;
		else if ((expSlot >= slotLoFirst) && (expSlot <= slotLoLast))
			expWord = {8'h00, l0RomAddr};
		else if (expSlot == slotSp)
			expWord = {sprPal, 16'h0000};
		else if ((expSlot >= slotFtFirst) && (expSlot <= slotFtLast))
			expWord = {8'h00, sRomAddr};
		else if ((expSlot >= slotXFirst) && (expSlot <= slotXLast))
			expWord = {8'h00, sprXpos, 8'h00};
		else
			expWord = {4'h0, fixPal, 16'h0000};	// Slots 14 and 15
	end

	assign expS1h1 = (expSlot >= 4'd8);
	assign expNVcs = !((expSlot >= slotXFirst) && (expSlot <= slotXLast));
	assign expFixPixel = (expSlot >= 4'd8) ? expFixByte[7:4] : expFixByte[3:0];

	// Fields taken at the edge that ends their slot
	always @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			expSprRomAddr <= '0;
			expSprPal <= '0;
			expFixRomAddr <= '0;
			expSprXpos <= '0;
			expFixPal <= '0;
			expFixByte <= '0;
			expFixPixelPal <= '0;
			expL0Data <= '0;
		end
		else
		begin
			if (expSlot == 4'd0)
				expSprRomAddr <= cRomAddr;
			if (expSlot == 4'd5)
				expL0Data <= l0RomData;
			if (expSlot == 4'd6)
				expSprPal <= sprPal;
			if (expSlot == 4'd8)
				expFixRomAddr <= sRomAddr;
			if (expSlot == 4'd13)
				expSprXpos <= sprXpos;
			if (expSlot == 4'd15)
			begin
				expFixPal <= fixPal;
				expFixByte <= fixRomData;
				expFixPixelPal <= expFixPal;	// Palette from the previous slot-15 edge
			end
		end
	end

	assign resetView = {2'b00, nVcs, s1h1, fixRomAddr, sprRomAddr, sprPalOut, sprXposOut,
		fixPalOut, fixPixel, fixPixelPal, l0Data};
	assign resetExp = {2'b00, 1'b1, 77'h0};	// Only nVcs high

	task automatic reportValue(input string testName, input logic [79:0] expected,
		input logic [79:0] actual);
	begin
		errorCount++;
		$display("FAILED %s expected %0h actual %0h", testName, expected, actual);
	end
	endtask

	resetChk: assert property (@(posedge CLK_24M) (inReset || firstCycle) |-> resetView == resetExp)
		else reportValue("resetState", $sampled(resetExp), $sampled(resetView));
	pBusWordChk: assert property (@(posedge CLK_24M) checkOn |-> pBus == expWord)
		else reportValue("pBusWord", $sampled(expWord), $sampled(pBus));
	s1h1Chk: assert property (@(posedge CLK_24M) checkOn |-> s1h1 == expS1h1)
		else reportValue("s1h1", $sampled(expS1h1), $sampled(s1h1));
	nVcsChk: assert property (@(posedge CLK_24M) checkOn |-> nVcs == expNVcs)
		else reportValue("nVcs", $sampled(expNVcs), $sampled(nVcs));
	sprRomAddrChk: assert property (@(posedge CLK_24M) checkOn |-> sprRomAddr == expSprRomAddr)
		else reportValue("sprRomAddr", $sampled(expSprRomAddr), $sampled(sprRomAddr));
	sprPalChk: assert property (@(posedge CLK_24M) checkOn |-> sprPalOut == expSprPal)
		else reportValue("sprPalOut", $sampled(expSprPal), $sampled(sprPalOut));
	fixRomAddrChk: assert property (@(posedge CLK_24M) checkOn |-> fixRomAddr == expFixRomAddr)
		else reportValue("fixRomAddr", $sampled(expFixRomAddr), $sampled(fixRomAddr));
	sprXposChk: assert property (@(posedge CLK_24M) checkOn |-> sprXposOut == expSprXpos)
		else reportValue("sprXposOut", $sampled(expSprXpos), $sampled(sprXposOut));
	fixPalChk: assert property (@(posedge CLK_24M) checkOn |-> fixPalOut == expFixPal)
		else reportValue("fixPalOut", $sampled(expFixPal), $sampled(fixPalOut));
	fixPixelChk: assert property (@(posedge CLK_24M) checkOn |-> fixPixel == expFixPixel)
		else reportValue("fixPixel", $sampled(expFixPixel), $sampled(fixPixel));
	fixPixelPalChk: assert property (@(posedge CLK_24M) checkOn |-> fixPixelPal == expFixPixelPal)
		else reportValue("fixPixelPal", $sampled(expFixPixelPal), $sampled(fixPixelPal));
	l0DataChk: assert property (@(posedge CLK_24M) checkOn |-> l0Data == expL0Data)
		else reportValue("l0Data", $sampled(expL0Data), $sampled(l0Data));

	// New random inputs, called right after a rising edge
	task automatic driveRandom();
		logic [31:0] rnd;
	begin
		rnd = $urandom;
		cRomAddr <= rnd[23:0];
		sprPal <= rnd[31:24];
		rnd = $urandom;
		sRomAddr <= rnd[15:0];
		l0RomAddr <= rnd[31:16];
		rnd = $urandom;
		sprXpos <= rnd[7:0];
		fixPal <= rnd[11:8];
		fixRomData <= rnd[23:16];
		l0RomData <= rnd[31:24];
	end
	endtask

	// Run until the edge that ends the given slot
	task automatic runToSlotEnd(input slotNum_t target, output logic found);
		int waited;
	begin
		found = 1'b0;
		waited = 0;
		while (!found && (waited < 20))
		begin
			@(posedge CLK_24M);
			driveRandom();
			if (expSlot == target)	// Slot that just ended
				found = 1'b1;
			waited++;
		end
	end
	endtask

	initial
	begin : mainFlow
		logic found;
		CLK_24M = 1'b0;
		void'($urandom(32'h6934));	// Single seed for the run
		nRESET <= 1'b0;
		sRomAddr <= '0;
		l0RomAddr <= '0;
		cRomAddr <= '0;
		sprPal <= '0;
		sprXpos <= '0;
		fixPal <= '0;
		fixRomData <= '0;
		l0RomData <= '0;
		repeat (10)
		begin
			@(posedge CLK_24M);
			driveRandom();
		end
		nRESET <= 1'b1;	// Released on the 10th edge
		// 48 full slot cycles of random data
		while (slotCycles < 48)
		begin
			runToSlotEnd(slotFpLast, found);
			if (!found)
			begin
				errorCount++;
				$display("Timed out waiting for the end of slot 15");
				break;
			end
			slotCycles++;
		end
		repeat (2) @(posedge CLK_24M);	// Let last checks settle
		$display("errors=%0d slotCycles=%0d clocks=%0d", errorCount, slotCycles, cycleCnt);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hw/pBusPkg.sv
hw/pBusIf.sv
hw/pCycleSeq.sv
hw/pBusLatch.sv
hw/fixPixelOut.sv
hw/pBusTop.sv
sim/pBusTb.sv
